// ==== Makefile ====
# Verilator build and run of the ramio testbench

VERILATOR ?= verilator
TOP       ?= ramio_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run $(TOP), look for the pass message in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^TESTS PASSED$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/access_decode.sv ====
// access decoder: address to target, byte lanes and lane-aligned write data
`include "ramio_defines.svh"

module access_decode (
  input  logic [`RAMIO_ADDR_W-1:0] address,
  input  ramio_pkg::write_size_e   write_type,
  input  logic [2:0]               read_type,
  input  logic                     enable,
  input  logic [`RAMIO_DATA_W-1:0] data_in,
  output ramio_pkg::access_t       access
);

  logic [1:0] offset;
  logic       wr_bad;  // misaligned half word store
  logic       rd_bad;  // misaligned half word load

  assign offset = address[1:0];
  assign wr_bad = (write_type == ramio_pkg::wr_half) && offset[0];
  assign rd_bad = (read_type[1:0] == ramio_pkg::ld_half) && offset[0];

  always_comb begin
    access = '0;

    unique case (address)
      `RAMIO_ADDR_LED:      access.target = ramio_pkg::tgt_led;
      `RAMIO_ADDR_UART_OUT: access.target = ramio_pkg::tgt_uart_out;
      `RAMIO_ADDR_UART_IN:  access.target = ramio_pkg::tgt_uart_in;
      default:              access.target = ramio_pkg::tgt_ram;
    endcase

    access.word_idx  = address[`RAMIO_RAM_IDX_W+1:2];  // aliases above ram depth
    access.offset    = offset;
    // load size survives a misaligned half so the result stage can answer zero
    access.load_size = enable ? ramio_pkg::load_size_e'(read_type[1:0]) : ramio_pkg::ld_none;
    access.is_signed = enable && read_type[2];
    access.is_read   = enable && (read_type[1:0] != 2'b00) && !rd_bad;
    access.is_write  = enable && (write_type != ramio_pkg::wr_none) && !wr_bad;

    // lanes only for ram, I/O registers look at size themselves
    if (access.is_write && access.target == ramio_pkg::tgt_ram) begin
      unique case (write_type)
        ramio_pkg::wr_byte: begin
          access.lane_we = 4'b0001 << offset;
          access.wr_data = {{(`RAMIO_DATA_W-8){1'b0}}, data_in[7:0]} << {offset, 3'b000};
        end
        ramio_pkg::wr_half: begin
          access.lane_we = 4'b0011 << {offset[1], 1'b0};
          access.wr_data = {{(`RAMIO_DATA_W-16){1'b0}}, data_in[15:0]} << {offset[1], 4'b0000};
        end
        ramio_pkg::wr_word: begin
          access.lane_we = 4'b1111;  // low address bits ignored
          access.wr_data = data_in;
        end
        default: ;
      endcase
    end
  end

  // bus master must not ask for a load and a store in the same cycle
  always_comb begin
    a_one_kind: assert final (!(access.is_read && access.is_write))
      else $error("load and store requested together at %h", address);
  end

endmodule

// ==== rtl/load_format.sv ====
// load result: picks I/O holding byte or RAM lane, then extends by size and sign
`include "ramio_defines.svh"

module load_format (
  input  ramio_pkg::access_t       access,     // registered with the ram read
  input  ramio_pkg::access_t       io_access,  // current access
  input  logic [`RAMIO_DATA_W-1:0] ram_data,
  input  logic                     ram_valid,
  input  logic [7:0]               tx_hold,
  input  logic [7:0]               rx_hold,
  output logic [`RAMIO_DATA_W-1:0] data,
  output logic                     data_ready
);

  logic                     io_read;
  logic                     io_uart_byte;
  logic                     ram_load;
  logic [7:0]               io_byte;
  logic [`RAMIO_DATA_W-1:0] lane_data;  // addressed lane moved to bit 0

  assign io_read      = io_access.is_read && (io_access.target != ramio_pkg::tgt_ram);
  assign io_uart_byte = (io_access.load_size == ramio_pkg::ld_byte) &&
                        (io_access.target inside {ramio_pkg::tgt_uart_out,
                                                  ramio_pkg::tgt_uart_in});
  assign io_byte      = (io_access.target == ramio_pkg::tgt_uart_in) ? rx_hold : tx_hold;
  assign ram_load     = (access.target == ramio_pkg::tgt_ram) &&
                        (access.load_size != ramio_pkg::ld_none);
  assign lane_data    = ram_data >> {access.offset, 3'b000};

  always_comb begin
    data       = '0;
    data_ready = 1'b0;
    if (io_read) begin  // I/O answers in the same cycle
      data_ready = 1'b1;
      if (io_uart_byte) begin
        data = io_access.is_signed ? {{(`RAMIO_DATA_W-8){io_byte[7]}}, io_byte}
                                   : {{(`RAMIO_DATA_W-8){1'b0}}, io_byte};
      end  // led and wider I/O reads give zero
    end else if (ram_load) begin
      data_ready = ram_valid || !access.is_read;  // misaligned half done with zero
      if (access.is_read) begin
        unique case (access.load_size)
          ramio_pkg::ld_byte:
            data = access.is_signed ? {{(`RAMIO_DATA_W-8){lane_data[7]}}, lane_data[7:0]}
                                    : {{(`RAMIO_DATA_W-8){1'b0}}, lane_data[7:0]};
          ramio_pkg::ld_half:
            data = access.is_signed ? {{(`RAMIO_DATA_W-16){lane_data[15]}}, lane_data[15:0]}
                                    : {{(`RAMIO_DATA_W-16){1'b0}}, lane_data[15:0]};
          default: data = ram_data;  // word ignores offset
        endcase
      end
    end
  end

  // the access register in the top and the ram read latency must line up
  always_comb begin
    a_ram_aligned: assert final (!(access.is_read && access.target == ramio_pkg::tgt_ram)
                                 || ram_valid)
      else $error("registered ram load without ram data valid");
  end

endmodule

// ==== rtl/ramio.sv ====
// load/store port top: LED and UART holding registers,
// access register for the RAM read stage, and the submodule instances
`include "ramio_defines.svh"

module ramio (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     enable,
  input  ramio_pkg::write_size_e   write_type,
  input  logic [2:0]               read_type,   // bit 2 signed, 1:0 size
  input  logic [`RAMIO_ADDR_W-1:0] address,     // byte address
  input  logic [`RAMIO_DATA_W-1:0] data_in,
  output logic [`RAMIO_DATA_W-1:0] data_out,
  output logic                     data_out_ready,
  output logic [3:0]               led,
  output logic                     uart_tx,
  input  logic                     uart_rx
);

  ramio_pkg::access_t       acc;      // current decoded access
  ramio_pkg::access_t       acc_q;    // follows the ram read by one cycle
  logic [`RAMIO_DATA_W-1:0] ram_rd_data;
  logic                     ram_rd_valid;
  logic [7:0]               tx_hold;  // byte being sent
  logic                     tx_go;
  logic                     tx_busy;
  logic [7:0]               rx_hold;  // last received byte, zero once read
  logic [7:0]               rx_data;
  logic                     rx_go;
  logic                     rx_ready;
  logic                     byte_wr;
  logic                     rx_rd;

  // I/O only reacts to byte stores and byte loads
  assign byte_wr = acc.is_write && (write_type == ramio_pkg::wr_byte);
  assign rx_rd   = acc.is_read && (acc.target == ramio_pkg::tgt_uart_in) &&
                   (acc.load_size == ramio_pkg::ld_byte);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q   <= '0;
      led     <= 4'b1111;  // all off
      tx_hold <= '0;
      tx_go   <= 1'b0;
      rx_hold <= '0;
      rx_go   <= 1'b1;
    end else begin
      acc_q <= acc;
      // rx: a read wins over a capture, the byte stays ready in uart_rx
      if (rx_rd) begin
        rx_hold <= '0;
      end else if (rx_go && rx_ready) begin
        rx_hold <= rx_data;
        rx_go   <= 1'b0;  // ack, one cycle low
      end
      if (!rx_go) begin
        rx_go <= 1'b1;
      end
      // tx: frame finished, release go and clear the byte
      if (tx_go && !tx_busy) begin
        tx_go   <= 1'b0;
        tx_hold <= '0;
      end
      if (byte_wr && acc.target == ramio_pkg::tgt_uart_out) begin
        tx_hold <= data_in[7:0];  // no restart if a frame is running
        tx_go   <= 1'b1;
      end
      if (byte_wr && acc.target == ramio_pkg::tgt_led) begin
        led <= data_in[3:0];
      end
    end
  end

  access_decode u_decode (
    .address,
    .write_type,
    .read_type,
    .enable,
    .data_in,
    .access (acc)
  );

  word_ram u_ram (
    .clk,
    .rst_n,
    .access   (acc),
    .rd_data  (ram_rd_data),
    .rd_valid (ram_rd_valid)
  );

  uart_tx u_tx (
    .clk,
    .rst_n,
    .data (tx_hold),
    .go   (tx_go),
    .tx   (uart_tx),
    .busy (tx_busy)
  );

  uart_rx u_rx (
    .clk,
    .rst_n,
    .rx         (uart_rx),
    .go         (rx_go),
    .data       (rx_data),
    .data_ready (rx_ready)
  );

  load_format u_fmt (
    .access     (acc_q),
    .io_access  (acc),
    .ram_data   (ram_rd_data),
    .ram_valid  (ram_rd_valid),
    .tx_hold,
    .rx_hold,
    .data       (data_out),
    .data_ready (data_out_ready)
  );

endmodule

// ==== rtl/ramio_defines.svh ====
// address and data widths, RAM depth
// I/O address map and UART bit timing
`ifndef RAMIO_DEFINES_SVH
`define RAMIO_DEFINES_SVH

`define RAMIO_ADDR_W 32     // byte address
`define RAMIO_DATA_W 32     // one word

// on-chip RAM
`define RAMIO_RAM_WORDS 256
`define RAMIO_RAM_IDX_W $clog2(`RAMIO_RAM_WORDS)  // word index bits

// I/O sits at the top three byte addresses
`define RAMIO_ADDR_LED      32'hffff_ffff
`define RAMIO_ADDR_UART_OUT 32'hffff_fffe
`define RAMIO_ADDR_UART_IN  32'hffff_fffd

// uart bit period in clocks
`define RAMIO_CLKS_PER_BIT 16

`endif

// ==== rtl/ramio_pkg.sv ====
// shared types: access size and target enums, decoded access struct
// and the uart FSM state enums
`include "ramio_defines.svh"

package ramio_pkg;

  // store size, same encoding as the write_type port
  typedef enum logic [1:0] {
    wr_none = 2'b00,
    wr_byte = 2'b01,
    wr_half = 2'b10,
    wr_word = 2'b11
  } write_size_e;

  // load size, low bits of read_type; bit 2 is the signed flag
  typedef enum logic [1:0] {
    ld_none = 2'b00,
    ld_byte = 2'b01,
    ld_half = 2'b10,
    ld_word = 2'b11
  } load_size_e;

  typedef enum logic [1:0] {
    tgt_ram,
    tgt_led,
    tgt_uart_out,
    tgt_uart_in
  } target_e;

  // one decoded access
  typedef struct packed {
    target_e                      target;
    logic [`RAMIO_RAM_IDX_W-1:0]  word_idx;   // ram word
    logic [3:0]                   lane_we;    // byte lane write enables
    logic [`RAMIO_DATA_W-1:0]     wr_data;    // already moved to its lanes
    load_size_e                   load_size;
    logic                         is_signed;
    logic [1:0]                   offset;     // byte within word
    logic                         is_read;
    logic                         is_write;
  } access_t;

  typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_e;
  typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

endpackage

// ==== rtl/uart_rx.sv ====
// 8N1 uart receiver, mid-bit sampling, data_ready held until go drops
`include "ramio_defines.svh"

module uart_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       go,
  output logic [7:0] data,
  output logic       data_ready
);

  localparam int unsigned CNT_W = $clog2(`RAMIO_CLKS_PER_BIT);

  ramio_pkg::rx_state_e state;
  logic [CNT_W-1:0]     cnt;
  logic [2:0]           bit_idx;
  logic                 rx_meta;   // first sync flop
  logic                 rx_sync;
  logic                 rx_prev;   // for the falling edge
  logic                 half_bit;
  logic                 full_bit;

  assign half_bit = (cnt == CNT_W'(`RAMIO_CLKS_PER_BIT / 2 - 1));
  assign full_bit = (cnt == CNT_W'(`RAMIO_CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ramio_pkg::rx_idle;
      cnt        <= '0;
      bit_idx    <= '0;
      data       <= '0;
      data_ready <= 1'b0;
    end else begin
      cnt <= cnt + 1'b1;
      unique case (state)
        ramio_pkg::rx_idle: begin
          cnt <= '0;
          if (rx_prev && !rx_sync) begin  // start edge
            state <= ramio_pkg::rx_start;
          end
        end
        ramio_pkg::rx_start: if (half_bit) begin
          cnt     <= '0;  // from here a full period lands mid bit
          bit_idx <= '0;
          state   <= rx_sync ? ramio_pkg::rx_idle : ramio_pkg::rx_data;  // glitch check
        end
        ramio_pkg::rx_data: if (full_bit) begin
          cnt     <= '0;
          data    <= {rx_sync, data[7:1]};  // lsb arrives first
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) begin
            state <= ramio_pkg::rx_stop;
          end
        end
        ramio_pkg::rx_stop: begin
          if (data_ready) begin
            cnt <= cnt;  // parked until the byte is taken
            if (!go) begin
              data_ready <= 1'b0;
              state      <= ramio_pkg::rx_idle;
            end
          end else if (full_bit) begin  // middle of stop bit
            if (go) begin
              data_ready <= 1'b1;
            end else begin
              state <= ramio_pkg::rx_idle;  // nobody listening, byte dropped
            end
          end
        end
        default: state <= ramio_pkg::rx_idle;
      endcase
    end
  end

endmodule

// ==== rtl/uart_tx.sv ====
// 8N1 uart transmitter, started by a go level
`include "ramio_defines.svh"

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] data,
  input  logic       go,
  output logic       tx,
  output logic       busy
);

  localparam int unsigned CNT_W = $clog2(`RAMIO_CLKS_PER_BIT);

  ramio_pkg::tx_state_e state;
  logic [CNT_W-1:0]     cnt;       // clocks within the bit
  logic [2:0]           bit_idx;
  logic [7:0]           shift;
  logic                 released;  // frame done, waiting for go to drop
  logic                 bit_end;

  assign bit_end = (cnt == CNT_W'(`RAMIO_CLKS_PER_BIT - 1));
  // high in the very cycle go rises so the holder keeps go up
  assign busy = (state != ramio_pkg::tx_idle) || (go && !released);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ramio_pkg::tx_idle;
      cnt      <= '0;
      bit_idx  <= '0;
      shift    <= '0;
      tx       <= 1'b1;  // line idles high
      released <= 1'b0;
    end else begin
      cnt <= bit_end ? '0 : cnt + 1'b1;
      unique case (state)
        ramio_pkg::tx_idle: begin
          cnt <= '0;
          if (!go) begin
            released <= 1'b0;
          end else if (!released) begin
            state <= ramio_pkg::tx_start;
            shift <= data;
            tx    <= 1'b0;  // start bit, one clock after go
          end
        end
        ramio_pkg::tx_start: if (bit_end) begin
          state   <= ramio_pkg::tx_data;
          bit_idx <= '0;
          tx      <= shift[0];  // lsb first
          shift   <= shift >> 1;
        end
        ramio_pkg::tx_data: if (bit_end) begin
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) begin
            state <= ramio_pkg::tx_stop;
            tx    <= 1'b1;
          end else begin
            tx    <= shift[0];
            shift <= shift >> 1;
          end
        end
        ramio_pkg::tx_stop: if (bit_end) begin
          state    <= ramio_pkg::tx_idle;
          released <= 1'b1;  // busy falls here
        end
        default: state <= ramio_pkg::tx_idle;
      endcase
    end
  end

  // holding byte stays put while its bits are on the line
  a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (state == ramio_pkg::tx_data) && $past(state == ramio_pkg::tx_data) |-> $stable(data))
    else $error("tx holding byte changed mid frame");

endmodule

// ==== rtl/word_ram.sv ====
// byte-lane word RAM, one cycle registered read with valid flag
`include "ramio_defines.svh"

module word_ram (
  input  logic                     clk,
  input  logic                     rst_n,
  input  ramio_pkg::access_t       access,
  output logic [`RAMIO_DATA_W-1:0] rd_data,
  output logic                     rd_valid
);

  logic [`RAMIO_DATA_W-1:0] mem [`RAMIO_RAM_WORDS];
  logic                     sel;  // access aimed at ram

  assign sel = (access.target == ramio_pkg::tgt_ram);

  // lane writes and read data
  always_ff @(posedge clk) begin
    if (sel && access.is_write) begin
      for (int i = 0; i < 4; i++) begin
        if (access.lane_we[i]) begin
          mem[access.word_idx][i*8 +: 8] <= access.wr_data[i*8 +: 8];
        end
      end
    end
    if (sel && access.is_read) begin
      rd_data <= mem[access.word_idx];  // whole word, result stage picks lanes
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= sel && access.is_read;  // exactly one cycle later
    end
  end

  // store lanes from the decoder never ride along with a load
  a_no_rw: assert property (@(posedge clk) disable iff (!rst_n)
    (access.lane_we != 4'b0000) |-> !access.is_read)
    else $error("byte lanes enabled during a read");

endmodule

// ==== src.f ====
+incdir+rtl
rtl/ramio_pkg.sv
rtl/access_decode.sv
rtl/word_ram.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/load_format.sv
rtl/ramio.sv
tb/ramio_tb.sv

// ==== tb/ramio_tb.sv ====
// ramio testbench with a table of accesses and expected values
// byte-addressed reference memory, uart loopback and a watchdog
`include "ramio_defines.svh"

module ramio_tb;

  localparam int clk_period  = 10;
  localparam int sample_dly  = 2;  // outputs settled well before the rising edge
  localparam int ready_limit = 8;  // clocks to wait for data_out_ready

  // read_type codes with bit 2 asking for sign extension
  localparam logic [2:0] rd_byte  = 3'b001;
  localparam logic [2:0] rd_half  = 3'b010;
  localparam logic [2:0] rd_word  = 3'b011;
  localparam logic [2:0] rd_sbyte = 3'b101;
  localparam logic [2:0] rd_shalf = 3'b110;

  typedef enum logic [1:0] {op_access, op_led, op_wait} op_e;

  typedef struct packed {
    op_e                    op;
    logic [3:0]             behavior;  // which behavior of the port is exercised
    ramio_pkg::write_size_e wr;
    logic [2:0]             rd;
    logic [31:0]            addr;
    logic [31:0]            data;      // store data or clocks for op_wait
    logic [31:0]            exp_val;
  } entry_t;

  logic                   clk;
  logic                   rst_n;
  logic                   enable;
  ramio_pkg::write_size_e write_type;
  logic [2:0]             read_type;
  logic [31:0]            address;
  logic [31:0]            data_in;
  logic [31:0]            data_out;
  logic                   data_out_ready;
  logic [3:0]             led;
  logic                   uart_line;  // tx looped back into rx

  entry_t      table_q[$];
  logic        table_ready = 1'b0;
  int          passes = 0;
  int          fails = 0;
  integer      seed;
  logic [7:0]  ref_mem [1024];  // byte image of the ram
  logic [3:0]  ref_led;
  logic [7:0]  ref_tx;          // byte in the uart out register
  logic [7:0]  ref_rx;          // byte waiting in uart in

  ramio UUT (
    .clk,
    .rst_n,
    .enable,
    .write_type,
    .read_type,
    .address,
    .data_in,
    .data_out,
    .data_out_ready,
    .led,
    .uart_tx (uart_line),
    .uart_rx (uart_line)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  // keep the loaded bits and fill the rest with the sign or with zeros
  function automatic logic [31:0] fit_load(input logic [31:0] v, input logic [1:0] size,
                                           input logic sgn);
    logic [31:0] keep;
    logic        top;
    case (size)
      2'b01: begin
        keep = 32'h0000_00ff;
        top  = v[7];
      end
      2'b10: begin
        keep = 32'h0000_ffff;
        top  = v[15];
      end
      default: begin
        keep = 32'hffff_ffff;
        top  = 1'b0;
      end
    endcase
    return (sgn && top) ? (v | ~keep) : (v & keep);
  endfunction

  // expected load value comes from the model before the model takes the store
  task automatic add_access(input int beh, input ramio_pkg::write_size_e wr,
                            input logic [2:0] rd, input logic [31:0] addr,
                            input logic [31:0] data);
    entry_t      e;
    logic [9:0]  a;     // byte within ram
    logic [9:0]  base;  // first byte of its word
    logic [1:0]  size;
    logic [31:0] v;
    a    = addr[9:0];
    base = {a[9:2], 2'b00};
    size = rd[1:0];
    v    = 32'd0;
    if (size != 2'b00) begin
      if (addr == `RAMIO_ADDR_UART_IN) begin
        if (size == 2'b01) begin
          v      = fit_load({24'd0, ref_rx}, size, rd[2]);
          ref_rx = 8'd0;  // consumed by the read
        end
      end else if (addr == `RAMIO_ADDR_UART_OUT) begin
        if (size == 2'b01) v = fit_load({24'd0, ref_tx}, size, rd[2]);
      end else if (addr != `RAMIO_ADDR_LED) begin
        case (size)
          2'b01: v = fit_load({24'd0, ref_mem[a]}, size, rd[2]);
          2'b10: v = a[0] ? 32'd0
                          : fit_load({16'd0, ref_mem[a + 10'd1], ref_mem[a]}, size, rd[2]);
          default: v = {ref_mem[base + 10'd3], ref_mem[base + 10'd2],
                        ref_mem[base + 10'd1], ref_mem[base]};  // offset ignored
        endcase
      end
    end
    if (addr == `RAMIO_ADDR_LED) begin
      if (wr == ramio_pkg::wr_byte) ref_led = data[3:0];
    end else if (addr == `RAMIO_ADDR_UART_OUT) begin
      if (wr == ramio_pkg::wr_byte) ref_tx = data[7:0];
    end else if (addr != `RAMIO_ADDR_UART_IN) begin
      case (wr)
        ramio_pkg::wr_byte: ref_mem[a] = data[7:0];
        ramio_pkg::wr_half: begin
          if (!a[0]) begin  // odd half words are dropped
            ref_mem[a]         = data[7:0];
            ref_mem[a + 10'd1] = data[15:8];
          end
        end
        ramio_pkg::wr_word: begin
          for (int i = 0; i < 4; i++) ref_mem[base + 10'(i)] = data[8*i +: 8];
        end
        default: ;
      endcase
    end
    e = '0;
    e.op       = op_access;
    e.behavior = 4'(beh);
    e.wr       = wr;
    e.rd       = rd;
    e.addr     = addr;
    e.data     = data;
    e.exp_val  = v;
    table_q.push_back(e);
  endtask

  task automatic add_led_check(input int beh);
    entry_t e;
    e = '0;
    e.op       = op_led;
    e.behavior = 4'(beh);
    e.exp_val  = {28'd0, ref_led};
    table_q.push_back(e);
  endtask

  // frame travels through the loopback while we wait
  task automatic add_wait(input int beh, input int clocks);
    entry_t e;
    e = '0;
    e.op       = op_wait;
    e.behavior = 4'(beh);
    e.data     = 32'(clocks);
    table_q.push_back(e);
    ref_rx = ref_tx;
    ref_tx = 8'd0;
  endtask

  task automatic build_table();
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    ref_led = 4'b1111;
    ref_tx  = 8'd0;
    ref_rx  = 8'd0;
    w0 = rnd() & 32'h0000_03fc;
    w1 = rnd() & 32'h0000_03fc;
    w2 = rnd() & 32'h0000_03fc;
    add_led_check(1);
    add_access(1, ramio_pkg::wr_word, 3'b000, w0, rnd());
    add_access(1, ramio_pkg::wr_none, rd_word, w0, 32'd0);
    add_access(2, ramio_pkg::wr_word, 3'b000, w1, rnd());
    add_access(2, ramio_pkg::wr_byte, 3'b000, w1 + 32'd1, rnd());
    add_access(2, ramio_pkg::wr_half, 3'b000, w1 + 32'd2, rnd());
    add_access(2, ramio_pkg::wr_none, rd_word, w1, 32'd0);
    add_access(2, ramio_pkg::wr_byte, 3'b000, w1 + 32'd3, rnd());
    add_access(2, ramio_pkg::wr_half, 3'b000, w1, rnd());
    add_access(2, ramio_pkg::wr_none, rd_word, w1, 32'd0);
    // bytes 1 and 2 negative and bytes 0 and 3 positive
    add_access(3, ramio_pkg::wr_word, 3'b000, w2, (rnd() & 32'h7f7f_7f7f) | 32'h0080_8000);
    for (int off = 0; off < 4; off++) begin
      add_access(3, ramio_pkg::wr_none, rd_byte, w2 + 32'(off), 32'd0);
      add_access(3, ramio_pkg::wr_none, rd_sbyte, w2 + 32'(off), 32'd0);
    end
    for (int off = 0; off < 4; off += 2) begin
      add_access(3, ramio_pkg::wr_none, rd_half, w2 + 32'(off), 32'd0);
      add_access(3, ramio_pkg::wr_none, rd_shalf, w2 + 32'(off), 32'd0);
    end
    add_access(4, ramio_pkg::wr_half, 3'b000, w1 + 32'd1, rnd());
    add_access(4, ramio_pkg::wr_half, 3'b000, w1 + 32'd3, rnd());
    add_access(4, ramio_pkg::wr_none, rd_word, w1, 32'd0);
    add_access(4, ramio_pkg::wr_none, rd_shalf, w1 + 32'd1, 32'd0);
    add_access(4, ramio_pkg::wr_none, rd_half, w1 + 32'd3, 32'd0);
    add_access(4, ramio_pkg::wr_none, rd_word, w2 + 32'd2, 32'd0);  // odd word reads aligned data
    // led value never matches its reset value or zero
    add_access(5, ramio_pkg::wr_byte, 3'b000, `RAMIO_ADDR_LED,
               (rnd() & 32'hffff_fffa) | 32'h1);
    add_led_check(5);
    add_access(5, ramio_pkg::wr_none, rd_byte, `RAMIO_ADDR_LED, 32'd0);
    add_led_check(5);
    add_access(6, ramio_pkg::wr_byte, 3'b000, `RAMIO_ADDR_UART_OUT, rnd() | 32'h80);
    add_wait(6, 12 * `RAMIO_CLKS_PER_BIT);
    add_access(6, ramio_pkg::wr_none, rd_sbyte, `RAMIO_ADDR_UART_IN, 32'd0);
    add_access(6, ramio_pkg::wr_none, rd_sbyte, `RAMIO_ADDR_UART_IN, 32'd0);
    add_access(6, ramio_pkg::wr_none, rd_byte, `RAMIO_ADDR_UART_OUT, 32'd0);
  endtask

  task automatic drive_idle();
    enable     = 1'b0;
    write_type = ramio_pkg::wr_none;
    read_type  = 3'b000;
    address    = 32'd0;
    data_in    = 32'd0;
  endtask

  task automatic check_value(input int idx, input entry_t e, input logic [31:0] got);
    assert (got === e.exp_val) begin
      passes++;
      $display("entry %0d (behavior %0d): %s at %h gave %h, ok", idx, e.behavior,
               (e.op == op_led) ? "led port" : "load", e.addr, got);
    end else begin
      fails++;
      $display("FAIL %0t: entry %0d (behavior %0d) %s at %h gave %h, expected %h", $time,
               idx, e.behavior, (e.op == op_led) ? "led port" : "load", e.addr, got, e.exp_val);
    end
  endtask

  // starts and ends on a falling edge
  task automatic run_entry(input int idx, input entry_t e);
    logic        ready;
    logic [31:0] got;
    int          waited;
    ready  = 1'b0;
    got    = 32'd0;
    waited = 0;
    case (e.op)
      op_led: begin
        #sample_dly;
        check_value(idx, e, {28'd0, led});
        @(negedge clk);
      end
      op_wait: begin
        repeat (e.data) @(negedge clk);
        $display("entry %0d (behavior %0d): waited %0d clocks", idx, e.behavior, e.data);
      end
      default: begin
        enable     = 1'b1;
        write_type = e.wr;
        read_type  = e.rd;
        address    = e.addr;
        data_in    = e.data;
        if (e.rd[1:0] == 2'b00) begin
          @(negedge clk);  // store taken on the rising edge in between
          $display("entry %0d (behavior %0d): store to %h done", idx, e.behavior, e.addr);
        end else begin
          while (!ready && waited < ready_limit) begin
            #sample_dly;
            if (data_out_ready) begin
              ready = 1'b1;
              got   = data_out;
            end
            waited++;
            @(negedge clk);
          end
          if (ready) begin
            check_value(idx, e, got);
          end else begin
            fails++;
            $display("entry %0d: load from %h got no data_out_ready within %0d clocks",
                     idx, e.addr, ready_limit);
          end
        end
        drive_idle();
        @(negedge clk);  // idle cycle flushes the ram read stage
      end
    endcase
  endtask

  initial begin
    seed  = 32'heaa28d46;
    rst_n = 1'b0;
    drive_idle();
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    foreach (table_q[i]) run_entry(i, table_q[i]);
    $display("%0d checks passed, %0d checks failed", passes, fails);
    if (fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // time budget of 20 clocks per entry plus 12 uart frames
  initial begin
    wait (table_ready);
    #((table_q.size() * 20 + 12 * 10 * `RAMIO_CLKS_PER_BIT) * clk_period);
    $display("watchdog: the run did not finish within its time budget");
    $display("TESTS FAILED");
    $finish;
  end

endmodule
